//--- aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
  input  logic [mipsPkg::dataW-1:0] a,
  input  logic [mipsPkg::dataW-1:0] b,
  input  mipsPkg::aluOpT            op,
  output logic [mipsPkg::dataW-1:0] res,
  output logic                      zero,
  output logic                      overflow
);

  logic [mipsPkg::dataW-1:0] sum;
  logic [mipsPkg::dataW-1:0] diff;
  logic                      addOvf;
  logic                      subOvf;

  assign sum  = a + b;
  assign diff = a - b;

  // Signed overflow from the operand and result signs
  assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
  assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

  always_comb begin
    res      = '0;
    overflow = 1'b0;
    case (op)
      mipsPkg::aluAnd: res = a & b;
      mipsPkg::aluOr:  res = a | b;
      mipsPkg::aluNor: res = ~(a | b);
      mipsPkg::aluAdd: begin
        res      = sum;
        overflow = addOvf;
      end
      mipsPkg::aluSub: begin
        res      = diff;
        overflow = subOvf;
      end
      // Sign of the true difference
      mipsPkg::aluSlt: res = {31'd0, diff[31] ^ subOvf};
      default: ;
    endcase
  end

  assign zero = (res == '0);

endmodule

//--- cpuChecker.sv
`timescale 1ns/10ps

module cpuChecker (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [mipsPkg::dataW-1:0] memAddr,
  input  logic [mipsPkg::dataW-1:0] dataOut,
  input  logic                      memRead,
  input  logic                      memWrite,
  input  logic                      memReady,
  input  logic [mipsPkg::dataW-1:0] pcCurrent,
  input  logic                      trap,
  output int                        errors,
  output int                        storesSeen,
  output logic                      trapSeen
);

  // Store records from word 256, count and trap PC at the top
  logic [31:0] trace [512];
  int          expCount;
  logic [31:0] trapPc;

  initial begin
    $readmemh("cpuTrace.txt", trace);
    expCount = trace[510];
    trapPc   = trace[511];
  end

  task automatic compareStore();
    logic [31:0] expAddr;
    logic [31:0] expData;
    if (storesSeen >= expCount) begin
      $display("Unexpected store to %h at %0t, only %0d stores were expected",
               memAddr, $time, expCount);
      errors++;
    end else begin
      expAddr = trace[256 + 2 * storesSeen];
      expData = trace[257 + 2 * storesSeen];
      if (memAddr !== expAddr || dataOut !== expData) begin
        $display("error at %0t: store %0d wrote %h to %h, expected %h to %h",
                 $time, storesSeen, dataOut, memAddr, expData, expAddr);
        errors++;
      end
    end
    storesSeen++;
  endtask

  task automatic inspectTrap();
    trapSeen = 1'b1;
    if (pcCurrent !== trapPc) begin
      $display("error at %0t: PC at trap is %h, expected %h", $time, pcCurrent, trapPc);
      errors++;
    end
    if (storesSeen != expCount) begin
      $display("Trap came after %0d stores, but %0d were expected", storesSeen, expCount);
      errors++;
    end
  endtask

  //////////////////////////////
  // Port monitor
  //////////////////////////////
  always @(posedge clk) begin
    if (!arstN) begin
      errors     = 0;
      storesSeen = 0;
      trapSeen   = 1'b0;
    end else begin
      if (memRead && memWrite) begin
        $display("Read and write strobes were both high at %0t", $time);
        errors++;
      end
      if (memWrite && memReady) begin
        compareStore();
      end
      if (trap && !trapSeen) begin
        inspectTrap();
      end else if (trapSeen && (memRead || memWrite || !trap)) begin
        $display("Core left the idle trap state at %0t", $time);
        errors++;
      end
    end
  end

endmodule

//--- cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

  logic                      clk;
  logic                      arstN;
  logic [mipsPkg::dataW-1:0] dataIn;
  logic                      memReady;
  logic [mipsPkg::dataW-1:0] memAddr;
  logic [mipsPkg::dataW-1:0] dataOut;
  logic                      memRead;
  logic                      memWrite;
  logic [mipsPkg::dataW-1:0] pcCurrent;
  logic                      trap;

  // Word memory, byte address bits 9:2
  logic [31:0] mem [256];
  logic [31:0] trace [512];
  int          seed;
  int          stallLeft;
  int          idx;
  int          cycles;
  int          maxCycles = 3000;
  int          holdCycles = 20;
  int          errors;
  int          storesSeen;
  logic        trapSeen;

  mipsCore UUT (
    .clk(clk), .arstN(arstN), .dataIn(dataIn), .memReady(memReady),
    .memAddr(memAddr), .dataOut(dataOut), .memRead(memRead), .memWrite(memWrite),
    .pcCurrent(pcCurrent), .trap(trap)
  );

  cpuChecker chk (
    .clk(clk), .arstN(arstN), .memAddr(memAddr), .dataOut(dataOut),
    .memRead(memRead), .memWrite(memWrite), .memReady(memReady),
    .pcCurrent(pcCurrent), .trap(trap),
    .errors(errors), .storesSeen(storesSeen), .trapSeen(trapSeen)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  //////////////////////////////
  // Memory model
  //////////////////////////////
  always @(posedge clk) begin
    if (arstN && memReady && (memRead || memWrite)) begin
      if (memWrite) begin
        mem[memAddr[9:2]] = dataOut;
      end
      // Gap before the next access may complete
      stallLeft = $random(seed) & 3;
    end
    #1;
    if (stallLeft > 0) begin
      memReady  = 1'b0;
      stallLeft = stallLeft - 1;
    end else begin
      memReady = 1'b1;
    end
    dataIn = memRead ? mem[memAddr[9:2]] : '0;
  end

  //////////////////////////////
  // Run control
  //////////////////////////////
  initial begin
    arstN     = 1'b0;
    dataIn    = '0;
    memReady  = 1'b1;
    seed      = 32'h5990;
    stallLeft = 0;
    // Unloaded words hold a pattern of their own index
    for (idx = 0; idx < 512; idx++) begin
      trace[idx] = 32'hBAD00000 | idx;
    end
    $readmemh("cpuTrace.txt", trace);
    for (idx = 0; idx < 256; idx++) begin
      mem[idx] = trace[idx];
    end

    repeat (16) @(posedge clk);
    #1 arstN = 1'b1;

    cycles = 0;
    while (trapSeen !== 1'b1 && cycles < maxCycles) begin
      @(negedge clk);
      cycles++;
    end

    if (trapSeen !== 1'b1) begin
      $display("Timeout: the core did not reach the trap within %0d cycles", maxCycles);
      $display("Checks failed");
      $finish;
    end else begin
      // Watch the bus stay idle after the trap
      cycles = 0;
      while (cycles < holdCycles) begin
        @(negedge clk);
        cycles++;
      end
      $display("Closing report: %0d errors, %0d stores seen", errors, storesSeen);
      if (errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

//--- cpuTrace.txt
// Program image as hex words, then store records as address and data pairs,
// then the expected store count and the PC seen at the trap
@000
20010007 2002FFFD 00221820 AC030200
00222022 AC040204 00222824 AC050208
00223025 AC06020C 00203827 AC070210
0041402A AC080214 3049FF0F AC090218
342A8000 AC0A021C 282BFFFF AC0B0220
8C0C03F0 018C6820 AC0D0224 20000055
AC000228 10220001 AC01022C 10210001
AC02022C 14210001 AC030230 14220001
AC020230 AC040234 08000025 AC020238
AC020238 0C000028 AC02023C AC02023C
AC1F0238 FC000000
// Load operand at byte address 3F0
@0FC
12345678
// Expected stores
@100
00000200 00000004 00000204 0000000A 00000208 00000005
0000020C FFFFFFFF 00000210 FFFFFFF8 00000214 00000001
00000218 0000FF0D 0000021C 00008007 00000220 00000000
00000224 2468ACF0 00000228 00000000 0000022C 00000007
00000230 00000004 00000234 0000000A 00000238 00000098
@1FE
0000000F 000000A8

//--- ctrlIf.sv
`timescale 1ns/10ps

// Control word from the FSM to the datapath
interface ctrlIf;
  logic              iorD;
  logic              irWrite;
  mipsPkg::regDstT   regDst;
  logic              regWrite;
  mipsPkg::memtoRegT memtoReg;
  logic              aluSrcA;
  mipsPkg::aluSrcBT  aluSrcB;
  mipsPkg::aluOpT    aluOp;
  mipsPkg::pcSourceT pcSource;
  logic              pcWrite;
  logic              pcWriteCond;
  logic              branchNe;

  modport ctrl (
    output iorD, irWrite, regDst, regWrite, memtoReg, aluSrcA,
    output aluSrcB, aluOp, pcSource, pcWrite, pcWriteCond, branchNe
  );

  modport path (
    input iorD, irWrite, regDst, regWrite, memtoReg, aluSrcA,
    input aluSrcB, aluOp, pcSource, pcWrite, pcWriteCond, branchNe
  );
endinterface

//--- list.f
mipsPkg.sv
ctrlIf.sv
aluUnit.sv
regFile.sv
mipsCtrl.sv
mdPath.sv
mipsCore.sv
cpuChecker.sv
cpuTb.sv

//--- mdPath.sv
`timescale 1ns/10ps

module mdPath (
  input  logic                           clk,
  input  logic                           arstN,
  ctrlIf.path                            cb,
  input  logic                           memReady,
  input  logic [mipsPkg::dataW-1:0]      dataIn,
  output logic [mipsPkg::dataW-1:0]      dataOut,
  output logic [mipsPkg::dataW-1:0]      memAddr,
  output logic [mipsPkg::dataW-1:0]      pcCurrent,
  output mipsPkg::opcodeT                opcode,
  output mipsPkg::functT                 funct,
  // ALU side
  output logic [mipsPkg::dataW-1:0]      aluA,
  output logic [mipsPkg::dataW-1:0]      aluB,
  output mipsPkg::aluOpT                 aluOp,
  input  logic [mipsPkg::dataW-1:0]      aluRes,
  input  logic                           aluZero,
  input  logic                           aluOverflow,
  // Register file side
  output logic [mipsPkg::regAddrW-1:0]   rAddrA,
  output logic [mipsPkg::regAddrW-1:0]   rAddrB,
  output logic [mipsPkg::regAddrW-1:0]   wAddr,
  output logic [mipsPkg::dataW-1:0]      wData,
  output logic                           regWe,
  input  logic [mipsPkg::dataW-1:0]      rDataA,
  input  logic [mipsPkg::dataW-1:0]      rDataB
);

  logic [mipsPkg::dataW-1:0] ir;
  logic [mipsPkg::dataW-1:0] mdr;
  logic [mipsPkg::dataW-1:0] aluOut;
  logic [mipsPkg::dataW-1:0] imm;
  logic [mipsPkg::dataW-1:0] jumpTarget;
  logic [mipsPkg::dataW-1:0] pcNext;
  logic                      zeroExt;
  logic                      pcLoad;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////
  assign opcode = mipsPkg::opcodeT'(ir[31:26]);
  assign funct  = mipsPkg::functT'(ir[5:0]);
  assign rAddrA = ir[25:21];
  assign rAddrB = ir[20:16];

  // Logical immediates are zero extended
  assign zeroExt    = (opcode == mipsPkg::opAndi) || (opcode == mipsPkg::opOri);
  assign imm        = zeroExt ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
  assign jumpTarget = {pcCurrent[31:28], ir[25:0], 2'b00};

  //////////////////////////////
  // Operand and address muxes
  //////////////////////////////
  assign aluA    = cb.aluSrcA ? rDataA : pcCurrent;
  assign aluOp   = cb.aluOp;
  assign memAddr = cb.iorD ? aluOut : pcCurrent;
  assign dataOut = rDataB;
  assign regWe   = cb.regWrite;

  always_comb begin
    case (cb.aluSrcB)
      mipsPkg::srcBFour:     aluB = 32'd4;
      mipsPkg::srcBImm:      aluB = imm;
      mipsPkg::srcBImmShift: aluB = {imm[29:0], 2'b00};
      default:               aluB = rDataB;
    endcase
  end

  always_comb begin
    case (cb.regDst)
      mipsPkg::dstRd:   wAddr = ir[15:11];
      mipsPkg::dstLink: wAddr = '1;
      default:          wAddr = ir[20:16];
    endcase
  end

  always_comb begin
    case (cb.memtoReg)
      mipsPkg::wbMdr: wData = mdr;
      mipsPkg::wbPc:  wData = pcCurrent;
      default:        wData = aluOut;
    endcase
  end

  always_comb begin
    case (cb.pcSource)
      mipsPkg::pcAluOut:     pcNext = aluOut;
      mipsPkg::pcJumpTarget: pcNext = jumpTarget;
      default:               pcNext = aluRes;
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////
  // Branch taken when zero matches the branch sense
  assign pcLoad = memReady && (cb.pcWrite || (cb.pcWriteCond && (aluZero != cb.branchNe)));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcCurrent <= mipsPkg::resetPc;
      ir        <= '0;
    end else begin
      if (pcLoad) begin
        pcCurrent <= pcNext;
      end
      if (cb.irWrite && memReady) begin
        ir <= dataIn;
      end
    end
  end

  // Frozen with the rest of the machine
  always_ff @(posedge clk) begin
    if (memReady) begin
      mdr    <= dataIn;
      aluOut <= aluRes;
    end
  end

  assert property (@(posedge clk) disable iff (!arstN) pcCurrent[1:0] == 2'b00);

  // Sequential PC increment never wraps
  assert property (@(posedge clk) disable iff (!arstN)
    (cb.pcWrite && cb.pcSource == mipsPkg::pcAluRes) |-> !aluOverflow);

endmodule

//--- mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [mipsPkg::dataW-1:0] dataIn,
  input  logic                      memReady,
  output logic [mipsPkg::dataW-1:0] memAddr,
  output logic [mipsPkg::dataW-1:0] dataOut,
  output logic                      memRead,
  output logic                      memWrite,
  output logic [mipsPkg::dataW-1:0] pcCurrent,
  output logic                      trap
);

  mipsPkg::opcodeT                opcode;
  mipsPkg::functT                 funct;
  mipsPkg::aluOpT                 aluOp;
  logic [mipsPkg::dataW-1:0]      aluA;
  logic [mipsPkg::dataW-1:0]      aluB;
  logic [mipsPkg::dataW-1:0]      aluRes;
  logic                           aluZero;
  logic                           aluOverflow;
  logic [mipsPkg::regAddrW-1:0]   rAddrA;
  logic [mipsPkg::regAddrW-1:0]   rAddrB;
  logic [mipsPkg::regAddrW-1:0]   wAddr;
  logic [mipsPkg::dataW-1:0]      wData;
  logic                           regWe;
  logic [mipsPkg::dataW-1:0]      rDataA;
  logic [mipsPkg::dataW-1:0]      rDataB;

  ctrlIf cb ();

  mipsCtrl ctrl (
    .clk(clk), .arstN(arstN), .opcode(opcode), .funct(funct), .memReady(memReady),
    .cb(cb.ctrl), .memRead(memRead), .memWrite(memWrite), .trap(trap)
  );

  mdPath path (
    .clk(clk), .arstN(arstN), .cb(cb.path), .memReady(memReady), .dataIn(dataIn),
    .dataOut(dataOut), .memAddr(memAddr), .pcCurrent(pcCurrent),
    .opcode(opcode), .funct(funct),
    .aluA(aluA), .aluB(aluB), .aluOp(aluOp), .aluRes(aluRes),
    .aluZero(aluZero), .aluOverflow(aluOverflow),
    .rAddrA(rAddrA), .rAddrB(rAddrB), .wAddr(wAddr), .wData(wData),
    .regWe(regWe), .rDataA(rDataA), .rDataB(rDataB)
  );

  aluUnit alu (
    .a(aluA), .b(aluB), .op(aluOp), .res(aluRes), .zero(aluZero), .overflow(aluOverflow)
  );

  regFile regs (
    .clk(clk), .arstN(arstN), .we(regWe), .rAddrA(rAddrA), .rAddrB(rAddrB),
    .wAddr(wAddr), .wData(wData), .rDataA(rDataA), .rDataB(rDataB)
  );

endmodule

//--- mipsCtrl.sv
`timescale 1ns/10ps

module mipsCtrl (
  input  logic            clk,
  input  logic            arstN,
  input  mipsPkg::opcodeT opcode,
  input  mipsPkg::functT  funct,
  input  logic            memReady,
  ctrlIf.ctrl             cb,
  output logic            memRead,
  output logic            memWrite,
  output logic            trap
);

  mipsPkg::ctrlStateT state;
  mipsPkg::ctrlStateT nextState;
  mipsPkg::aluOpT     rOp;
  mipsPkg::aluOpT     iOp;
  logic               rValid;
  logic               run;

  //////////////////////////////
  // Instruction decode
  //////////////////////////////
  always_comb begin
    rValid = 1'b1;
    rOp    = mipsPkg::aluAdd;
    case (funct)
      mipsPkg::fnAdd: rOp = mipsPkg::aluAdd;
      mipsPkg::fnSub: rOp = mipsPkg::aluSub;
      mipsPkg::fnAnd: rOp = mipsPkg::aluAnd;
      mipsPkg::fnOr:  rOp = mipsPkg::aluOr;
      mipsPkg::fnNor: rOp = mipsPkg::aluNor;
      mipsPkg::fnSlt: rOp = mipsPkg::aluSlt;
      default:        rValid = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      mipsPkg::opAndi: iOp = mipsPkg::aluAnd;
      mipsPkg::opOri:  iOp = mipsPkg::aluOr;
      mipsPkg::opSlti: iOp = mipsPkg::aluSlt;
      default:         iOp = mipsPkg::aluAdd;
    endcase
  end

  //////////////////////////////
  // State register
  //////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      mipsPkg::stFetch: nextState = mipsPkg::stDecode;
      mipsPkg::stDecode: begin
        case (opcode)
          mipsPkg::opRType: nextState = rValid ? mipsPkg::stExecR : mipsPkg::stTrap;
          mipsPkg::opLw, mipsPkg::opSw: nextState = mipsPkg::stMemAddr;
          mipsPkg::opBeq, mipsPkg::opBne: nextState = mipsPkg::stBranch;
          mipsPkg::opJ, mipsPkg::opJal: nextState = mipsPkg::stJump;
          mipsPkg::opAddi, mipsPkg::opAndi,
          mipsPkg::opOri, mipsPkg::opSlti: nextState = mipsPkg::stExecI;
          default: nextState = mipsPkg::stTrap;
        endcase
      end
      mipsPkg::stMemAddr: begin
        nextState = (opcode == mipsPkg::opLw) ? mipsPkg::stMemRead : mipsPkg::stMemWrite;
      end
      mipsPkg::stMemRead: nextState = mipsPkg::stMemWb;
      mipsPkg::stExecR:   nextState = mipsPkg::stRWb;
      mipsPkg::stExecI:   nextState = mipsPkg::stIWb;
      mipsPkg::stTrap:    nextState = mipsPkg::stTrap;
      default:            nextState = mipsPkg::stFetch;
    endcase
  end

  // First fetch starts one cycle after reset release
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= mipsPkg::stFetch;
      run   <= 1'b0;
    end else begin
      run <= 1'b1;
      // Whole machine stalls while memory is busy
      if (run && memReady) begin
        state <= nextState;
      end
    end
  end

  //////////////////////////////
  // Control word
  //////////////////////////////
  always_comb begin
    cb.iorD        = 1'b0;
    cb.irWrite     = 1'b0;
    cb.regDst      = mipsPkg::dstRt;
    cb.regWrite    = 1'b0;
    cb.memtoReg    = mipsPkg::wbAluOut;
    cb.aluSrcA     = 1'b0;
    cb.aluSrcB     = mipsPkg::srcBRegB;
    cb.aluOp       = mipsPkg::aluAdd;
    cb.pcSource    = mipsPkg::pcAluRes;
    cb.pcWrite     = 1'b0;
    cb.pcWriteCond = 1'b0;
    cb.branchNe    = 1'b0;
    memRead        = 1'b0;
    memWrite       = 1'b0;
    if (run) begin
      case (state)
        mipsPkg::stFetch: begin
          memRead    = 1'b1;
          cb.irWrite = 1'b1;
          cb.aluSrcB = mipsPkg::srcBFour;
          cb.pcWrite = 1'b1;
        end
        // Branch target into ALUOut
        mipsPkg::stDecode: cb.aluSrcB = mipsPkg::srcBImmShift;
        mipsPkg::stMemAddr: begin
          cb.aluSrcA = 1'b1;
          cb.aluSrcB = mipsPkg::srcBImm;
        end
        mipsPkg::stMemRead: begin
          memRead = 1'b1;
          cb.iorD = 1'b1;
        end
        mipsPkg::stMemWb: begin
          cb.memtoReg = mipsPkg::wbMdr;
          cb.regWrite = 1'b1;
        end
        mipsPkg::stMemWrite: begin
          memWrite = 1'b1;
          cb.iorD  = 1'b1;
        end
        mipsPkg::stExecR: begin
          cb.aluSrcA = 1'b1;
          cb.aluOp   = rOp;
        end
        mipsPkg::stRWb: begin
          cb.regDst   = mipsPkg::dstRd;
          cb.regWrite = 1'b1;
        end
        mipsPkg::stExecI: begin
          cb.aluSrcA = 1'b1;
          cb.aluSrcB = mipsPkg::srcBImm;
          cb.aluOp   = iOp;
        end
        mipsPkg::stIWb: cb.regWrite = 1'b1;
        mipsPkg::stBranch: begin
          cb.aluSrcA     = 1'b1;
          cb.aluOp       = mipsPkg::aluSub;
          cb.pcSource    = mipsPkg::pcAluOut;
          cb.pcWriteCond = 1'b1;
          cb.branchNe    = (opcode == mipsPkg::opBne);
        end
        mipsPkg::stJump: begin
          cb.pcSource = mipsPkg::pcJumpTarget;
          cb.pcWrite  = 1'b1;
          // jal links the already incremented PC
          if (opcode == mipsPkg::opJal) begin
            cb.regDst   = mipsPkg::dstLink;
            cb.memtoReg = mipsPkg::wbPc;
            cb.regWrite = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign trap = (state == mipsPkg::stTrap);

  // Bus strobes are exclusive
  assert property (@(posedge clk) disable iff (!arstN) !(memRead && memWrite));

  // Trap holds until reset
  assert property (@(posedge clk) disable iff (!arstN) trap |=> trap);

endmodule

//--- mipsPkg.sv
package mipsPkg;

  //////////////////////////////
  // Widths and reset values
  //////////////////////////////
  localparam int dataW    = 32;
  localparam int regAddrW = 5;

  localparam logic [dataW-1:0] resetPc = '0;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////
  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opBne   = 6'h05,
    opAddi  = 6'h08,
    opSlti  = 6'h0a,
    opAndi  = 6'h0c,
    opOri   = 6'h0d,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnNor = 6'h27,
    fnSlt = 6'h2a
  } functT;

  // ALU operation codes
  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluNor = 3'b100,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOpT;

  //////////////////////////////
  // Controller states
  //////////////////////////////
  typedef enum logic [3:0] {
    stFetch, stDecode, stMemAddr, stMemRead, stMemWb, stMemWrite,
    stExecR, stRWb, stExecI, stIWb, stBranch, stJump, stTrap
  } ctrlStateT;

  // Datapath selectors
  typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstT;
  typedef enum logic [1:0] {wbAluOut, wbMdr, wbPc} memtoRegT;
  typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBImmShift} aluSrcBT;
  typedef enum logic [1:0] {pcAluRes, pcAluOut, pcJumpTarget} pcSourceT;

endpackage

//--- regFile.sv
`timescale 1ns/10ps

module regFile (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         we,
  input  logic [mipsPkg::regAddrW-1:0] rAddrA,
  input  logic [mipsPkg::regAddrW-1:0] rAddrB,
  input  logic [mipsPkg::regAddrW-1:0] wAddr,
  input  logic [mipsPkg::dataW-1:0]    wData,
  output logic [mipsPkg::dataW-1:0]    rDataA,
  output logic [mipsPkg::dataW-1:0]    rDataB
);

  logic [mipsPkg::dataW-1:0] regs [2**mipsPkg::regAddrW];

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////
  // Register 0 is hardwired to zero
  assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
  assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

  assert property (@(posedge clk) disable iff (!arstN) we |-> !$isunknown(wAddr));

endmodule
